/* uart_line_pkg.sv */
// Serial line constants shared by the transmitter, the receiver and the checkers.
// Refer to the names with uart_line_pkg:: scoping.

`default_nettype none

package uart_line_pkg;

    // Data bits per frame, sent least significant bit first
    localparam int frame_data_bits = 8;

    // Mark level of an idle line; a start bit is the opposite level
    localparam logic line_idle = 1'b1;

    // Width of the bit and sample timing counters
    localparam int tick_cnt_w = 16;

endpackage

`default_nettype wire

/* uart_reg_pkg.sv */
// CPU-side register definitions of the terminal port.
// Holds the bus address codes and the terminal word, which is read either
// as a raw byte or as a flag bit on top of a seven-bit character.

`default_nettype none

package uart_reg_pkg;

    // Register addresses on the two-bit bus
    typedef enum logic [1:0] {
        addr_rx   = 2'b00,
        addr_rxcr = 2'b01,
        addr_tx   = 2'b10
    } reg_addr_t;

    // Terminal word with bit 7 as the status flag
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       flag;
            logic [6:0] ascii;
        } fields;
    } term_word_u;

endpackage

`default_nettype wire

/* uart_tx.sv */
// Serial transmitter for the terminal port.
// A tx_start pulse loads one frame (start, 8 data bits, stop) and shifts it
// out on txd; tx_busy stays high until the stop bit has completed.

`default_nettype none

module uart_tx #(
    parameter int clk_freq = 25000000,
    parameter int baud     = 115200
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       txd
);

    localparam int bit_cycles = clk_freq / baud;
    localparam int frame_bits = uart_line_pkg::frame_data_bits + 2;
    localparam int bit_cnt_w  = $clog2(frame_bits);

    logic [uart_line_pkg::tick_cnt_w-1:0] tick_cnt;
    logic [bit_cnt_w-1:0]                 bit_cnt;
    logic [frame_bits-1:0]                shift_reg;
    logic                                 bit_end;

    assign bit_end = (tick_cnt == uart_line_pkg::tick_cnt_w'(bit_cycles - 1));

    // Line bit is always the low end of the shifter
    assign txd = shift_reg[0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tx_busy   <= 1'b0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            shift_reg <= {frame_bits{uart_line_pkg::line_idle}};
        end
        else if (!tx_busy)
        begin
            if (tx_start)
            begin
                tx_busy   <= 1'b1;
                tick_cnt  <= '0;
                bit_cnt   <= '0;
                // Stop bit, data, start bit
                shift_reg <= {uart_line_pkg::line_idle, tx_byte, ~uart_line_pkg::line_idle};
            end
        end
        else if (bit_end)
        begin
            tick_cnt  <= '0;
            // Fill with idle so the line rests at mark after the stop bit
            shift_reg <= {uart_line_pkg::line_idle, shift_reg[frame_bits-1:1]};
            if (bit_cnt == bit_cnt_w'(frame_bits - 1))
                tx_busy <= 1'b0;
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
// Oversampling serial receiver for the terminal port.
// A falling edge on rxd starts the sample clock; the start bit is checked at
// mid-bit, then data and stop bits are sampled one bit period apart.
// rx_done pulses for a good stop bit, rx_active covers the whole frame.

`default_nettype none

module uart_rx #(
    parameter int clk_freq     = 25000000,
    parameter int baud         = 115200,
    parameter int oversampling = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic       rx_done,
    output logic [7:0] rx_byte,
    output logic       rx_active
);

    localparam int sample_cycles = clk_freq / (baud * oversampling);
    localparam int os_w          = $clog2(oversampling + 1);
    localparam int bit_w         = $clog2(uart_line_pkg::frame_data_bits);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic [1:0]                           sync;
    logic                                 rxd_prev;
    logic [1:0]                           state;
    logic [uart_line_pkg::tick_cnt_w-1:0] tick_cnt;
    logic [os_w-1:0]                      os_cnt;
    logic [bit_w-1:0]                     bit_idx;
    logic                                 sample_tick;
    logic                                 mid_start;
    logic                                 bit_end;

    assign sample_tick = (tick_cnt == uart_line_pkg::tick_cnt_w'(sample_cycles - 1));
    assign mid_start   = sample_tick && (os_cnt == os_w'(oversampling / 2 - 1));
    assign bit_end     = sample_tick && (os_cnt == os_w'(oversampling - 1));
    assign rx_active   = (state != st_idle);

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync     <= {2{uart_line_pkg::line_idle}};
            rxd_prev <= uart_line_pkg::line_idle;
        end
        else
        begin
            sync     <= {sync[0], rxd};
            rxd_prev <= sync[1];
        end
    end

    // Sample clock held at zero while idle, so it is phase aligned to the start edge
    always_ff @(posedge clk)
    begin
        if (!rst_n || state == st_idle || sample_tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= st_idle;
            os_cnt  <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (sample_tick)
                os_cnt <= os_cnt + 1'b1;
            case (state)
                st_idle:
                begin
                    os_cnt <= '0;
                    if (rxd_prev == uart_line_pkg::line_idle && sync[1] != uart_line_pkg::line_idle)
                        state <= st_start;
                end
                st_start:
                    if (mid_start)
                    begin
                        os_cnt  <= '0;
                        bit_idx <= '0;
                        // A glitch that is back at idle by mid-bit is not a start bit
                        state   <= (sync[1] != uart_line_pkg::line_idle) ? st_data : st_idle;
                    end
                st_data:
                    if (bit_end)
                    begin
                        os_cnt <= '0;
                        if (bit_idx == bit_w'(uart_line_pkg::frame_data_bits - 1))
                            state <= st_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                default:
                    if (bit_end)
                    begin
                        // Framing error drops the byte silently
                        rx_done <= (sync[1] == uart_line_pkg::line_idle);
                        state   <= st_idle;
                    end
            endcase
        end
    end

    // Data shifts in from the top, least significant bit first
    always_ff @(posedge clk)
    begin
        if (state == st_data && bit_end)
            rx_byte <= {sync[1], rx_byte[7:1]};
    end

endmodule

`default_nettype wire

/* uart_regs.sv */
// Bus register block of the terminal port.
// Decodes RX, RXCR and TX accesses, holds the received character with its
// pending flag, starts transmissions and drives clear-to-send.

`default_nettype none

module uart_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  uart_reg_pkg::reg_addr_t address,
    input  logic                    w_en,
    input  logic [7:0]              din,
    input  logic                    tx_busy,
    input  logic                    rx_done,
    input  logic [7:0]              rx_byte,
    input  logic                    rx_active,
    output logic [7:0]              dout,
    output logic                    tx_start,
    output logic [7:0]              tx_byte,
    output logic                    cts
);

    uart_reg_pkg::term_word_u wr_word;
    uart_reg_pkg::term_word_u rx_word;
    uart_reg_pkg::term_word_u rd_word;

    logic       pending;
    logic       rx_ack;
    logic       rx_load;
    logic       tx_write;
    logic [6:0] rx_char;

    assign wr_word.raw = din;
    assign rx_word.raw = rx_byte;

    // Busy also covers the cycle of the start pulse, before tx_busy rises
    assign tx_write = enable && w_en && (address == uart_reg_pkg::addr_tx)
                      && !tx_busy && !tx_start;

    // A byte arriving while one is pending is lost
    assign rx_load = rx_done && !pending;

    assign cts = rx_active || pending;

    // Read word for the addressed register
    always_comb
    begin
        rd_word.raw = '0;
        case (address)
            uart_reg_pkg::addr_tx:   rd_word.fields.flag = tx_busy;
            uart_reg_pkg::addr_rxcr: rd_word.fields.flag = pending;
            uart_reg_pkg::addr_rx:
            begin
                rd_word.fields.flag  = pending;
                rd_word.fields.ascii = rx_char;
            end
            default: rd_word.raw = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tx_start <= 1'b0;
            rx_ack   <= 1'b0;
            pending  <= 1'b0;
            dout     <= '0;
        end
        else
        begin
            tx_start <= tx_write;
            rx_ack   <= enable && !w_en && (address == uart_reg_pkg::addr_rx);
            pending  <= rx_load || (pending && !rx_ack);
            if (enable && !w_en)
                dout <= rd_word.raw;
        end
    end

    // Terminal is 7-bit so bit 7 always goes out as zero
    always_ff @(posedge clk)
    begin
        if (tx_write)
            tx_byte <= {1'b0, wr_word.fields.ascii};
        if (rx_load)
            rx_char <= rx_word.fields.ascii;
    end

endmodule

`default_nettype wire

/* apple1_uart.sv */
// Top level of the Apple 1 style serial terminal port.
// Set clk_freq, baud and oversampling here; they pass down unchanged to the
// transmitter and the receiver. The register block sits on the CPU bus.

`default_nettype none

module apple1_uart #(
    parameter int clk_freq     = 25000000,
    parameter int baud         = 115200,
    parameter int oversampling = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  uart_reg_pkg::reg_addr_t address,
    input  logic                    w_en,
    input  logic [7:0]              din,
    output logic [7:0]              dout,
    input  logic                    uart_rx,
    output logic                    uart_tx,
    output logic                    uart_cts
);

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       rx_done;
    logic [7:0] rx_byte;
    logic       rx_active;

    uart_tx #(.clk_freq(clk_freq), .baud(baud)) u_tx (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_busy(tx_busy), .txd(uart_tx)
    );

    uart_rx #(.clk_freq(clk_freq), .baud(baud), .oversampling(oversampling)) u_rx (
        .clk(clk), .rst_n(rst_n), .rxd(uart_rx),
        .rx_done(rx_done), .rx_byte(rx_byte), .rx_active(rx_active)
    );

    uart_regs u_regs (
        .clk(clk), .rst_n(rst_n), .enable(enable), .address(address), .w_en(w_en),
        .din(din), .tx_busy(tx_busy), .rx_done(rx_done), .rx_byte(rx_byte),
        .rx_active(rx_active), .dout(dout), .tx_start(tx_start), .tx_byte(tx_byte),
        .cts(uart_cts)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Free-running testbench clock, 8 ns period, starting low.
// Instantiate once in the testbench top and take clk from its port.

`default_nettype none

module tb_clock_gen #(
    parameter int half_period_ns = 4
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

endmodule

`default_nettype wire

/* apple1_uart_assertions.sv */
// Concurrent checks on the terminal port, bound into every apple1_uart.
// Covers the idle TX line, clear-to-send once a received byte is pending and the TX start rule.

`default_nettype none

module apple1_uart_assertions (
    input logic clk,
    input logic rst_n,
    input logic tx_busy,
    input logic tx_start,
    input logic rx_done,
    input logic pending,
    input logic uart_tx,
    input logic uart_cts
);
    timeunit 1ns;
    timeprecision 100ps;

    // Line rests at mark whenever no frame is being sent
    assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> uart_tx == uart_line_pkg::line_idle)
        else $error("uart_tx not idle while the transmitter is not busy");

    // A byte taken into the empty register holds clear-to-send up from the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) rx_done && !pending |=> uart_cts)
        else $error("uart_cts low after a received byte became pending");

    assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
        else $error("tx_start issued while the transmitter is busy");

endmodule

bind apple1_uart apple1_uart_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .tx_busy(tx_busy), .tx_start(tx_start), .rx_done(rx_done),
    .pending(u_regs.pending), .uart_tx(uart_tx), .uart_cts(uart_cts)
);

`default_nettype wire

/* apple1_uart_tb.sv */
// Testbench for the Apple 1 style terminal port.
// Drives the CPU bus and the serial input, decodes frames from the serial
// output and compares read words against a reference model.

`default_nettype none

module apple1_uart_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_freq     = 2000000;
    localparam int baud         = 125000;
    localparam int oversampling = 4;
    localparam int bit_clocks   = clk_freq / baud;
    localparam int frame_ns     = 10 * bit_clocks * 8;
    localparam int watchdog_ns  = 40 * frame_ns + 4000;
    localparam int poll_limit   = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    enable;
    uart_reg_pkg::reg_addr_t address;
    logic                    w_en;
    logic [7:0]              din;
    logic [7:0]              dout;
    logic                    uart_rx;
    logic                    uart_tx;
    logic                    uart_cts;

    int          errors;
    int          errors_mark;
    int          checks_run;
    logic [31:0] rng;
    string       name_q[$];
    logic [7:0]  exp_q[$];
    logic [7:0]  act_q[$];

    tb_clock_gen u_clk (.clk(clk));

    apple1_uart #(.clk_freq(clk_freq), .baud(baud), .oversampling(oversampling)) u_apple1_uart (
        .clk(clk), .rst_n(rst_n), .enable(enable), .address(address), .w_en(w_en),
        .din(din), .dout(dout), .uart_rx(uart_rx), .uart_tx(uart_tx), .uart_cts(uart_cts)
    );

    // Expected bus word with the status flag on top of the seven-bit character
    function automatic logic [7:0] expected_word(input logic [7:0] sent, input logic flag);
        uart_reg_pkg::term_word_u w;
        w.fields.flag  = flag;
        w.fields.ascii = sent[6:0];
        return w.raw;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks_run++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        end
    endtask

    task automatic queue_check(input string name, input logic [7:0] exp, input logic [7:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // Comparator drains the observations queued by the tests
    always @(posedge clk)
    begin
        while (act_q.size() > 0)
            compare_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    task automatic bus_write(input uart_reg_pkg::reg_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        enable  <= 1'b1;
        w_en    <= 1'b1;
        address <= addr;
        din     <= data;
        @(posedge clk);
        enable <= 1'b0;
        w_en   <= 1'b0;
    endtask

    // dout is registered, so it is taken half a cycle after the sampling edge
    task automatic bus_read(input uart_reg_pkg::reg_addr_t addr, output logic [7:0] data);
        @(posedge clk);
        enable  <= 1'b1;
        w_en    <= 1'b0;
        address <= addr;
        @(posedge clk);
        enable <= 1'b0;
        @(negedge clk);
        data = dout;
    endtask

    task automatic poll_flag(input uart_reg_pkg::reg_addr_t addr, input logic level,
                             input string what);
        logic [7:0] word;
        int         n;
        n = 1;
        bus_read(addr, word);
        while (word[7] !== level && n < poll_limit)
        begin
            bus_read(addr, word);
            n++;
        end
        if (word[7] !== level)
        begin
            errors++;
            $display("%s flag did not reach %0d within %0d reads", what, level, n);
        end
    endtask

    // Serial line model sending a start bit, eight data bits LSB first and a stop bit
    task automatic send_frame(input logic [7:0] b);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            uart_rx <= bits[i];
            repeat (bit_clocks - 1) @(posedge clk);
        end
    endtask

    // Frame decoder that samples each bit near its middle
    task automatic capture_frame(output logic start_bit, output logic [7:0] data,
                                 output logic stop_bit);
        int i;
        @(negedge uart_tx);
        repeat (bit_clocks / 2) @(negedge clk);
        start_bit = uart_tx;
        for (i = 0; i < 8; i++)
        begin
            repeat (bit_clocks) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (bit_clocks) @(negedge clk);
        stop_bit = uart_tx;
    endtask

    task automatic check_frame(input logic [7:0] ch, input logic sb, input logic [7:0] got,
                               input logic pb);
        queue_check("uart_tx start bit", 8'd0, {7'd0, sb});
        queue_check("uart_tx data", expected_word(ch, 1'b0), got);
        queue_check("uart_tx stop bit", 8'd1, {7'd0, pb});
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        @(negedge clk);
        $display("%-20s %s, %0d errors", name, (errors == errors_mark) ? "ok" : "failed",
                 errors - errors_mark);
        errors_mark = errors;
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic [7:0] word;
        logic [7:0] ch;
        logic [7:0] ch2;
        logic [7:0] got;
        logic       sb;
        logic       pb;
        logic       mid_cts;
        logic       quiet;
        int         k;
        rst_n       = 1'b0;
        enable      = 1'b0;
        w_en        = 1'b0;
        address     = uart_reg_pkg::addr_rx;
        din         = 8'd0;
        uart_rx     = 1'b1;
        errors      = 0;
        errors_mark = 0;
        checks_run  = 0;
        rng         = 32'h972d;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        queue_check("uart_tx", 8'd1, {7'd0, uart_tx});
        queue_check("uart_cts", 8'd0, {7'd0, uart_cts});
        queue_check("dout", 8'd0, dout);
        bus_read(uart_reg_pkg::addr_tx, word);
        queue_check("dout TX", expected_word(8'd0, 1'b0), word);
        bus_read(uart_reg_pkg::addr_rxcr, word);
        queue_check("dout RXCR", expected_word(8'd0, 1'b0), word);
        finish_test("reset state");

        for (k = 0; k < 4; k++)
        begin
            rng = xorshift32(rng);
            ch  = rng[7:0];
            poll_flag(uart_reg_pkg::addr_tx, 1'b0, "TX busy");
            fork
                capture_frame(sb, got, pb);
                begin
                    bus_write(uart_reg_pkg::addr_tx, ch);
                    bus_read(uart_reg_pkg::addr_tx, word);
                end
            join
            queue_check("dout TX busy", expected_word(8'd0, 1'b1), word);
            check_frame(ch, sb, got, pb);
        end
        finish_test("transmit");

        rng = xorshift32(rng);
        ch  = rng[7:0];
        ch2 = {1'b0, ~ch[6:0]};
        poll_flag(uart_reg_pkg::addr_tx, 1'b0, "TX busy");
        fork
            capture_frame(sb, got, pb);
            begin
                bus_write(uart_reg_pkg::addr_tx, ch);
                bus_read(uart_reg_pkg::addr_tx, word);
                if (word[7])
                    bus_write(uart_reg_pkg::addr_tx, ch2);
            end
        join
        queue_check("dout TX busy", expected_word(8'd0, 1'b1), word);
        check_frame(ch, sb, got, pb);
        poll_flag(uart_reg_pkg::addr_tx, 1'b0, "TX busy");
        // The dropped write must not show up as a second frame
        quiet = 1'b1;
        repeat (2 * bit_clocks)
        begin
            @(negedge clk);
            if (uart_tx !== 1'b1)
                quiet = 1'b0;
        end
        queue_check("uart_tx idle after drop", 8'd1, {7'd0, quiet});
        fork
            capture_frame(sb, got, pb);
            bus_write(uart_reg_pkg::addr_tx, ch2);
        join
        check_frame(ch2, sb, got, pb);
        finish_test("write while busy");

        for (k = 0; k < 4; k++)
        begin
            rng = xorshift32(rng);
            ch  = rng[7:0];
            fork
                send_frame(ch);
                begin
                    repeat (3 * bit_clocks) @(negedge clk);
                    mid_cts = uart_cts;
                end
            join
            queue_check("uart_cts in frame", 8'd1, {7'd0, mid_cts});
            poll_flag(uart_reg_pkg::addr_rxcr, 1'b1, "RX pending");
            queue_check("uart_cts pending", 8'd1, {7'd0, uart_cts});
            bus_read(uart_reg_pkg::addr_rx, word);
            queue_check("dout RX", expected_word(ch, 1'b1), word);
            bus_read(uart_reg_pkg::addr_rxcr, word);
            queue_check("dout RXCR", expected_word(8'd0, 1'b0), word);
            queue_check("uart_cts after read", 8'd0, {7'd0, uart_cts});
        end
        finish_test("receive and cts");

        rng = xorshift32(rng);
        ch  = rng[7:0];
        ch2 = ch ^ 8'h55;
        send_frame(ch);
        send_frame(ch2);
        poll_flag(uart_reg_pkg::addr_rxcr, 1'b1, "RX pending");
        bus_read(uart_reg_pkg::addr_rx, word);
        queue_check("dout RX overrun", expected_word(ch, 1'b1), word);
        bus_read(uart_reg_pkg::addr_rxcr, word);
        queue_check("dout RXCR overrun", expected_word(8'd0, 1'b0), word);
        finish_test("overrun");

        $display("Finished: %0d checks, %0d errors", checks_run, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
uart_line_pkg.sv
uart_reg_pkg.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
apple1_uart.sv
tb_clock_gen.sv
apple1_uart_assertions.sv
apple1_uart_tb.sv

/* Makefile */
TOP = apple1_uart_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
